/* include/ace_settings.svh */
`ifndef ACE_SETTINGS_SVH
`define ACE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// bus and buffer sizes
////////////////////////////////////////////////////////////
`define ACE_ADDR_W 7
`define ACE_DATA_W 16
`define ACE_LBA_W 28
// one sector read is 16 words, trace keeps 16 records
`define ACE_BUF_DEPTH 16
`define ACE_IDX_W 4
`define ACE_CNT_W 5

////////////////////////////////////////////////////////////
// MPU register map, word addresses
////////////////////////////////////////////////////////////
`define ACE_REG_STATUS_L 7'h02
`define ACE_REG_STATUS_U 7'h03
`define ACE_REG_ERROR_L 7'h04
`define ACE_REG_LBA_L 7'h08
`define ACE_REG_LBA_U 7'h09
`define ACE_REG_SECCNT_CMD 7'h0a
`define ACE_REG_CONTROL_L 7'h0c
// data buffer window spans 0x20 to 0x2f
`define ACE_REG_DATABUF 7'h20

// status bits, lower half unless noted
`define ACE_ST_CFGDONE_BIT 3
`define ACE_ST_CFDETECT_BIT 8
`define ACE_ST_LOCKED_BIT 1
// upper half
`define ACE_ST_RDYCMD_BIT 3

// control and command words
`define ACE_CTL_LOCKREQ 16'h0002
`define ACE_CTL_CFGRST 16'h0040
`define ACE_CMD_READ 16'h0300
`define ACE_SECCNT_ONE 16'h0001

`endif

/* hdl/acePkg.sv */
`include "ace_settings.svh"

package acePkg;

	// one word on the MPU data bus
	typedef logic [`ACE_DATA_W-1:0] aceWord_t;

	// single register access, sequencer to bus port
	typedef struct packed {
		logic wr;
		logic [`ACE_ADDR_W-1:0] addr;
		aceWord_t wdata;
	} aceReq_t;

	// result of a finished access, zero after a write
	typedef struct packed {
		aceWord_t rdata;
	} aceRsp_t;

	// everything that goes out to the pins
	// strobes active low, doutEn drives the pad
	typedef struct packed {
		logic [`ACE_ADDR_W-1:0] addr;
		aceWord_t dout;
		logic doutEn;
		logic ceN;
		logic oeN;
		logic weN;
	} aceBus_t;

	// two ASCII characters per step
	typedef enum logic [15:0] {
		trcEE = 16'h4545,
		trcCF = 16'h4346,
		trcGR = 16'h4752,
		trcLW = 16'h4c57,
		trcLC = 16'h4c43,
		trcLE = 16'h4c45,
		trcRD = 16'h5244,
		trcNR = 16'h4e52,
		trcLB = 16'h4c42,
		trcSC = 16'h5343,
		trcCM = 16'h434d,
		trcRT = 16'h5254,
		trcCL = 16'h434c,
		trcRL = 16'h524c
	} traceCode_t;

	// step code plus register value seen in that step
	typedef struct packed {
		traceCode_t code;
		aceWord_t value;
	} traceEntry_t;

endpackage

/* hdl/captureBuffer.sv */
`timescale 1ns/1ps
`include "ace_settings.svh"

module captureBuffer #(
	parameter type entry_t = logic [`ACE_DATA_W-1:0]
) (
	input logic sys_Ace_clk,
	input logic rst,
	input logic clear,
	input logic wr,
	input entry_t wrData,
	input logic [`ACE_IDX_W-1:0] rdIndex,
	output entry_t rdData,
	output logic [`ACE_CNT_W-1:0] fill
);

	entry_t mem [`ACE_BUF_DEPTH];
	logic full;

	// write pointer doubles as fill count
	assign full = (fill == `ACE_CNT_W'(`ACE_BUF_DEPTH));

	always_ff @(posedge sys_Ace_clk or posedge rst) begin
		if (rst) begin
			fill <= '0;
		end else if (clear) begin
			fill <= '0;
		end else if (wr && !full) begin
			fill <= fill + 1'b1;
		end
	end

	// extra writes dropped once full
	always_ff @(posedge sys_Ace_clk) begin
		if (wr && !clear && !full) begin
			mem[fill[`ACE_IDX_W-1:0]] <= wrData;
		end
	end

	// combinational read port
	assign rdData = mem[rdIndex];

endmodule

/* hdl/aceBusPort.sv */
`timescale 1ns/1ps
`include "ace_settings.svh"

module aceBusPort (
	input logic sys_Ace_clk,
	input logic rst,
	input logic busStart,
	input acePkg::aceReq_t busReq,
	input acePkg::aceWord_t mpdIn,
	input logic mpBrdy,
	output logic busDone,
	output acePkg::aceRsp_t busRsp,
	output acePkg::aceBus_t mpu
);
	import acePkg::*;

	aceReq_t reqReg;
	aceWord_t rspData;
	logic [2:0] phase;
	logic waitRdy;
	logic inWindow;
	logic doutEn;
	logic ceN;
	logic oeN;
	logic weN;

	// data buffer window needs buffer ready first
	assign inWindow = (busReq.addr >= `ACE_REG_DATABUF) &&
		(busReq.addr < `ACE_REG_DATABUF + `ACE_BUF_DEPTH);

	////////////////////////////////////////////////////////////
	// strobe sequence
	////////////////////////////////////////////////////////////
	// phase 1 CE low, 2..3 OE or WE low, 4 done
	always_ff @(posedge sys_Ace_clk or posedge rst) begin
		if (rst) begin
			phase <= '0;
			waitRdy <= 1'b0;
			busDone <= 1'b0;
			doutEn <= 1'b0;
			ceN <= 1'b1;
			oeN <= 1'b1;
			weN <= 1'b1;
		end else begin
			busDone <= 1'b0;
			if (busStart && inWindow) begin
				// hold CE high until the buffer is ready
				waitRdy <= 1'b1;
			end else if (busStart || (waitRdy && mpBrdy)) begin
				waitRdy <= 1'b0;
				phase <= 3'd1;
				ceN <= 1'b0;
				doutEn <= busStart ? busReq.wr : reqReg.wr;
			end else begin
				case (phase)
					3'd1: begin
						phase <= 3'd2;
						oeN <= reqReg.wr;
						weN <= !reqReg.wr;
					end
					3'd2: phase <= 3'd3;
					3'd3: begin
						// sample edge, strobes up
						phase <= 3'd4;
						oeN <= 1'b1;
						weN <= 1'b1;
						busDone <= 1'b1;
					end
					3'd4: begin
						phase <= '0;
						ceN <= 1'b1;
						doutEn <= 1'b0;
					end
					default: phase <= '0;
				endcase
			end
		end
	end

	// request held stable for the whole access
	always_ff @(posedge sys_Ace_clk) begin
		if (busStart) begin
			reqReg <= busReq;
		end
		if (phase == 3'd3) begin
			rspData <= reqReg.wr ? '0 : mpdIn;
		end
	end

	assign busRsp.rdata = rspData;

	// pin bundle
	assign mpu.addr = reqReg.addr;
	assign mpu.dout = reqReg.wdata;
	assign mpu.doutEn = doutEn;
	assign mpu.ceN = ceN;
	assign mpu.oeN = oeN;
	assign mpu.weN = weN;

endmodule

/* hdl/aceSequencer.sv */
`timescale 1ns/1ps
`include "ace_settings.svh"

module aceSequencer (
	input logic sys_Ace_clk,
	input logic rst,
	input logic readStart,
	input logic [`ACE_LBA_W-1:0] sectorLba,
	input logic busDone,
	input acePkg::aceRsp_t busRsp,
	output logic busStart,
	output acePkg::aceReq_t busReq,
	output logic traceWr,
	output acePkg::traceEntry_t traceData,
	output logic wordWr,
	output acePkg::aceWord_t wordData,
	output logic runClear,
	output logic busy,
	output logic readDone
);
	import acePkg::*;

	typedef enum logic [3:0] {
		stIdle, stErrRead, stCfCheck, stLockReq, stLockCheck,
		stReadyCheck, stLbaLow, stLbaHigh, stSecCount, stCommand,
		stCfgReset, stStream, stCfgClear, stRelease, stDone
	} step_t;

	step_t step;
	step_t nextStep;
	logic waitBus;
	logic [`ACE_IDX_W-1:0] wordCnt;
	logic [`ACE_LBA_W-1:0] lbaReg;
	logic startRun;
	logic pollOk;
	logic logTrace;
	traceCode_t nextCode;
	aceWord_t rd;

	assign startRun = (step == stIdle) && readStart;
	assign rd = busRsp.rdata;

	////////////////////////////////////////////////////////////
	// access select per step
	////////////////////////////////////////////////////////////
	always_comb begin
		busReq.wr = 1'b1;
		busReq.addr = `ACE_REG_CONTROL_L;
		busReq.wdata = '0;
		case (step)
			stErrRead: begin
				busReq.wr = 1'b0;
				busReq.addr = `ACE_REG_ERROR_L;
			end
			stCfCheck, stLockCheck: begin
				busReq.wr = 1'b0;
				busReq.addr = `ACE_REG_STATUS_L;
			end
			stLockReq: busReq.wdata = `ACE_CTL_LOCKREQ;
			stReadyCheck: begin
				busReq.wr = 1'b0;
				busReq.addr = `ACE_REG_STATUS_U;
			end
			stLbaLow: begin
				busReq.addr = `ACE_REG_LBA_L;
				busReq.wdata = lbaReg[`ACE_DATA_W-1:0];
			end
			stLbaHigh: begin
				// upper 12 bits, zero extended
				busReq.addr = `ACE_REG_LBA_U;
				busReq.wdata = aceWord_t'(lbaReg[`ACE_LBA_W-1:`ACE_DATA_W]);
			end
			stSecCount: begin
				busReq.addr = `ACE_REG_SECCNT_CMD;
				busReq.wdata = `ACE_SECCNT_ONE;
			end
			stCommand: begin
				busReq.addr = `ACE_REG_SECCNT_CMD;
				busReq.wdata = `ACE_CMD_READ;
			end
			stCfgReset: busReq.wdata = `ACE_CTL_CFGRST;
			stStream: begin
				busReq.wr = 1'b0;
				busReq.addr = `ACE_REG_DATABUF + {3'b000, wordCnt};
			end
			// clear and release both write control 0
			default: busReq.wdata = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// read evaluation, next step and trace code
	////////////////////////////////////////////////////////////
	always_comb begin
		pollOk = 1'b1;
		logTrace = 1'b1;
		nextStep = step;
		nextCode = trcEE;
		case (step)
			stErrRead: nextStep = stCfCheck;
			stCfCheck: begin
				// card present and no config in progress
				pollOk = !rd[`ACE_ST_CFGDONE_BIT] && rd[`ACE_ST_CFDETECT_BIT];
				nextCode = pollOk ? trcCF : trcGR;
				nextStep = pollOk ? stLockReq : stCfCheck;
			end
			stLockReq: begin
				nextCode = trcLW;
				nextStep = stLockCheck;
			end
			stLockCheck: begin
				pollOk = rd[`ACE_ST_LOCKED_BIT];
				nextCode = pollOk ? trcLC : trcLE;
				nextStep = pollOk ? stReadyCheck : stLockCheck;
			end
			stReadyCheck: begin
				pollOk = rd[`ACE_ST_RDYCMD_BIT];
				nextCode = pollOk ? trcRD : trcNR;
				nextStep = pollOk ? stLbaLow : stReadyCheck;
			end
			stLbaLow: begin
				// one LB entry covers both halves
				logTrace = 1'b0;
				nextStep = stLbaHigh;
			end
			stLbaHigh: begin
				nextCode = trcLB;
				nextStep = stSecCount;
			end
			stSecCount: begin
				nextCode = trcSC;
				nextStep = stCommand;
			end
			stCommand: begin
				nextCode = trcCM;
				nextStep = stCfgReset;
			end
			stCfgReset: begin
				nextCode = trcRT;
				nextStep = stStream;
			end
			stStream: begin
				logTrace = 1'b0;
				if (wordCnt == `ACE_IDX_W'(`ACE_BUF_DEPTH - 1)) begin
					nextStep = stCfgClear;
				end
			end
			stCfgClear: begin
				nextCode = trcCL;
				nextStep = stRelease;
			end
			stRelease: begin
				nextCode = trcRL;
				nextStep = stDone;
			end
			default: logTrace = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// step register and pulse outputs
	////////////////////////////////////////////////////////////
	always_ff @(posedge sys_Ace_clk or posedge rst) begin
		if (rst) begin
			step <= stIdle;
			waitBus <= 1'b0;
			wordCnt <= '0;
			busStart <= 1'b0;
			traceWr <= 1'b0;
			wordWr <= 1'b0;
			runClear <= 1'b0;
			busy <= 1'b0;
			readDone <= 1'b0;
		end else begin
			// single cycle pulses by default
			busStart <= 1'b0;
			traceWr <= 1'b0;
			wordWr <= 1'b0;
			runClear <= 1'b0;
			readDone <= 1'b0;
			case (step)
				stIdle: begin
					if (startRun) begin
						step <= stErrRead;
						busy <= 1'b1;
						runClear <= 1'b1;
						wordCnt <= '0;
					end
				end
				stDone: begin
					// last trace write has landed by now
					readDone <= 1'b1;
					busy <= 1'b0;
					step <= stIdle;
				end
				default: begin
					if (!waitBus) begin
						busStart <= 1'b1;
						waitBus <= 1'b1;
					end else if (busDone) begin
						waitBus <= 1'b0;
						step <= nextStep;
						traceWr <= logTrace;
						if (step == stStream) begin
							wordWr <= 1'b1;
							wordCnt <= wordCnt + 1'b1;
						end
					end
				end
			endcase
		end
	end

	// payload, sampled with the control above
	always_ff @(posedge sys_Ace_clk) begin
		if (startRun) begin
			lbaReg <= sectorLba;
		end
		if (busDone) begin
			traceData.code <= nextCode;
			traceData.value <= rd;
			wordData <= rd;
		end
	end

endmodule

/* hdl/aceReader.sv */
`timescale 1ns/1ps
`include "ace_settings.svh"

module aceReader (
	input logic sys_Ace_clk,
	input logic rst,
	input logic readStart,
	input logic [`ACE_LBA_W-1:0] sectorLba,
	input acePkg::aceWord_t mpdIn,
	input logic mpBrdy,
	input logic [`ACE_IDX_W-1:0] wordIndex,
	input logic [`ACE_IDX_W-1:0] traceIndex,
	output acePkg::aceBus_t mpu,
	output logic busy,
	output logic readDone,
	output acePkg::aceWord_t word,
	output logic [`ACE_CNT_W-1:0] wordCount,
	output acePkg::traceEntry_t trace,
	output logic [`ACE_CNT_W-1:0] traceCount
);
	import acePkg::*;

	////////////////////////////////////////////////////////////
	// internal links
	////////////////////////////////////////////////////////////
	logic busStart;
	logic busDone;
	aceReq_t busReq;
	aceRsp_t busRsp;
	logic traceWr;
	traceEntry_t traceData;
	logic wordWr;
	aceWord_t wordData;
	logic runClear;

	// decode
	aceSequencer i_sequencer (
		.sys_Ace_clk(sys_Ace_clk), .rst(rst), .readStart(readStart), .sectorLba(sectorLba),
		.busDone(busDone), .busRsp(busRsp), .busStart(busStart), .busReq(busReq),
		.traceWr(traceWr), .traceData(traceData), .wordWr(wordWr), .wordData(wordData),
		.runClear(runClear), .busy(busy), .readDone(readDone)
	);

	// execute, MPU pins
	aceBusPort i_busPort (
		.sys_Ace_clk(sys_Ace_clk), .rst(rst), .busStart(busStart), .busReq(busReq),
		.mpdIn(mpdIn), .mpBrdy(mpBrdy), .busDone(busDone), .busRsp(busRsp), .mpu(mpu)
	);

	// sector words
	captureBuffer #(.entry_t(aceWord_t)) i_wordBuf (
		.sys_Ace_clk(sys_Ace_clk), .rst(rst), .clear(runClear), .wr(wordWr),
		.wrData(wordData), .rdIndex(wordIndex), .rdData(word), .fill(wordCount)
	);

	// step trace
	captureBuffer #(.entry_t(traceEntry_t)) i_traceBuf (
		.sys_Ace_clk(sys_Ace_clk), .rst(rst), .clear(runClear), .wr(traceWr),
		.wrData(traceData), .rdIndex(traceIndex), .rdData(trace), .fill(traceCount)
	);

endmodule

/* tb/aceReader_assertions.sv */
`timescale 1ns/1ps
`include "ace_settings.svh"

module aceReader_assertions (
	input logic sys_Ace_clk,
	input logic rst,
	input acePkg::aceBus_t mpu,
	input logic readDone
);

	// number of failed assertions so far
	int failCount = 0;

	////////////////////////////////////////////////////////////
	// MPU strobes
	////////////////////////////////////////////////////////////
	strobeExclusive: assert property (@(posedge sys_Ace_clk) disable iff (rst)
		!(!mpu.weN && !mpu.oeN))
	else begin
		failCount++;
		$error("write enable and output enable low together");
	end

	// CE brackets both OE and WE
	chipEnableCover: assert property (@(posedge sys_Ace_clk) disable iff (rst)
		(!mpu.weN || !mpu.oeN) |-> !mpu.ceN)
	else begin
		failCount++;
		$error("strobe low while chip enable is high");
	end

	// end of run
	donePulse: assert property (@(posedge sys_Ace_clk) disable iff (rst)
		readDone |=> !readDone)
	else begin
		failCount++;
		$error("readDone high for more than one cycle");
	end

endmodule

bind aceReader aceReader_assertions i_assertions (
	.sys_Ace_clk(sys_Ace_clk), .rst(rst), .mpu(mpu), .readDone(readDone)
);

/* tb/aceReader_tb.sv */
`timescale 1ns/1ps
`include "ace_settings.svh"

module aceReader_tb;
	import acePkg::*;

	localparam int nRows = 6;
	localparam int doneLimit = 2000;
	localparam aceWord_t stCard = aceWord_t'(1 << `ACE_ST_CFDETECT_BIT);
	localparam aceWord_t stLocked = aceWord_t'(1 << `ACE_ST_LOCKED_BIT);
	localparam aceWord_t stReady = aceWord_t'(1 << `ACE_ST_RDYCMD_BIT);
	// configuration still running
	localparam aceWord_t stCfgBusy = aceWord_t'(1 << `ACE_ST_CFGDONE_BIT);

	// fail counts are polls answered negative before the good one
	typedef struct packed {
		logic [`ACE_LBA_W-1:0] lba;
		logic [1:0] statusFails;
		logic [1:0] lockFails;
		logic [1:0] nrFails;
		aceWord_t errVal;
	} row_t;

	typedef struct packed {
		logic [`ACE_ADDR_W-1:0] addr;
		aceWord_t data;
	} writeRec_t;

	logic sys_Ace_clk = 1'b0;
	logic rst;
	logic readStart;
	logic [`ACE_LBA_W-1:0] sectorLba;
	aceWord_t mpdIn = '0;
	logic mpBrdy = 1'b0;
	logic [`ACE_IDX_W-1:0] wordIndex;
	logic [`ACE_IDX_W-1:0] traceIndex;
	aceBus_t mpu;
	logic busy;
	logic readDone;
	aceWord_t word;
	logic [`ACE_CNT_W-1:0] wordCount;
	traceEntry_t trace;
	logic [`ACE_CNT_W-1:0] traceCount;

	row_t rows [nRows];
	row_t curRow = '0;
	integer seed = 32'hb752b107;
	int valueErrs = 0;
	int otherErrs = 0;
	writeRec_t expWrites [$];
	logic [31:0] expTrace [$];

	// System ACE model state
	writeRec_t writeLog [$];
	aceWord_t ctlReg = '0;
	aceWord_t lbaLowReg = '0;
	logic [1:0] statusSeen = '0;
	logic [1:0] lockSeen = '0;
	logic [1:0] nrSeen = '0;
	logic prevOeN = 1'b1;
	logic prevWeN = 1'b1;
	logic [2:0] rdyWait = '0;

	aceReader i_dut (
		.sys_Ace_clk(sys_Ace_clk), .rst(rst), .readStart(readStart), .sectorLba(sectorLba),
		.mpdIn(mpdIn), .mpBrdy(mpBrdy), .wordIndex(wordIndex), .traceIndex(traceIndex),
		.mpu(mpu), .busy(busy), .readDone(readDone), .word(word), .wordCount(wordCount),
		.trace(trace), .traceCount(traceCount)
	);

	initial begin
		forever #20 sys_Ace_clk = ~sys_Ace_clk;
	end

	////////////////////////////////////////////////////////////
	// System ACE register model
	////////////////////////////////////////////////////////////
	function automatic logic inWindow(input logic [`ACE_ADDR_W-1:0] a);
		return (a >= `ACE_REG_DATABUF) && (a < `ACE_REG_DATABUF + `ACE_BUF_DEPTH);
	endfunction

	function automatic aceWord_t modelRead(input logic [`ACE_ADDR_W-1:0] a);
		aceWord_t v;
		v = '0;
		if (inWindow(a)) begin
			v = lbaLowReg + aceWord_t'(a - `ACE_REG_DATABUF);
		end else if (a == `ACE_REG_ERROR_L) begin
			v = curRow.errVal;
		end else if (a == `ACE_REG_STATUS_U) begin
			v = (nrSeen < curRow.nrFails) ? '0 : stReady;
		end else if (a == `ACE_REG_STATUS_L && (ctlReg & `ACE_CTL_LOCKREQ) == '0) begin
			// no lock requested yet so this is the card detect poll
			// first miss has no card, second has a card still configuring
			if (statusSeen >= curRow.statusFails) begin
				v = stCard;
			end else if (statusSeen == 0) begin
				v = '0;
			end else begin
				v = stCard | stCfgBusy;
			end
		end else if (a == `ACE_REG_STATUS_L) begin
			v = (lockSeen < curRow.lockFails) ? stCard : (stCard | stLocked);
		end
		return v;
	endfunction

	always @(posedge sys_Ace_clk) begin
		prevOeN <= mpu.oeN;
		prevWeN <= mpu.weN;
		mpdIn <= modelRead(mpu.addr);
		// second low OE cycle where the DUT samples
		if (!mpu.oeN && !prevOeN) begin
			checkTrue(!mpu.doutEn, "data output enable was high during a read strobe");
			if (mpu.addr == `ACE_REG_ERROR_L) begin
				// error read opens every run
				statusSeen <= '0;
				lockSeen <= '0;
				nrSeen <= '0;
				writeLog.delete();
			end else if (mpu.addr == `ACE_REG_STATUS_U && nrSeen < curRow.nrFails) begin
				nrSeen <= nrSeen + 1'b1;
			end else if (mpu.addr == `ACE_REG_STATUS_L) begin
				if ((ctlReg & `ACE_CTL_LOCKREQ) == '0) begin
					if (statusSeen < curRow.statusFails) statusSeen <= statusSeen + 1'b1;
				end else if (lockSeen < curRow.lockFails) begin
					lockSeen <= lockSeen + 1'b1;
				end
			end
		end
		if (!mpu.weN && !prevWeN) begin
			checkTrue(mpu.doutEn, "data output enable was low during a write strobe");
			writeLog.push_back({mpu.addr, mpu.dout});
			if (mpu.addr == `ACE_REG_CONTROL_L) ctlReg <= mpu.dout;
			if (mpu.addr == `ACE_REG_LBA_L) lbaLowReg <= mpu.dout;
		end
		// buffer ready after a random hold counted from when the window address shows
		if (!mpu.ceN) begin
			mpBrdy <= 1'b0;
			rdyWait <= 3'($random(seed));
		end else if (inWindow(mpu.addr)) begin
			if (rdyWait != 0) rdyWait <= rdyWait - 1'b1;
			else mpBrdy <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// checks and expected values
	////////////////////////////////////////////////////////////
	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			valueErrs++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		assert (cond) else begin
			otherErrs++;
			$display("%s", what);
		end
	endtask

	task automatic buildExpected(input row_t r);
		string tail;
		tail = "LBSCCMRTCLRL";
		expWrites.delete();
		expWrites.push_back({`ACE_REG_CONTROL_L, `ACE_CTL_LOCKREQ});
		expWrites.push_back({`ACE_REG_LBA_L, r.lba[15:0]});
		expWrites.push_back({`ACE_REG_LBA_U, 4'h0, r.lba[27:16]});
		expWrites.push_back({`ACE_REG_SECCNT_CMD, `ACE_SECCNT_ONE});
		expWrites.push_back({`ACE_REG_SECCNT_CMD, `ACE_CMD_READ});
		expWrites.push_back({`ACE_REG_CONTROL_L, `ACE_CTL_CFGRST});
		expWrites.push_back({`ACE_REG_CONTROL_L, 16'h0000});
		expWrites.push_back({`ACE_REG_CONTROL_L, 16'h0000});
		// step codes in run order with the value read or zero
		expTrace.delete();
		expTrace.push_back({"EE", r.errVal});
		for (int i = 0; i < r.statusFails; i++) begin
			expTrace.push_back({"GR", (i == 0) ? 16'h0000 : (stCard | stCfgBusy)});
		end
		expTrace.push_back({"CF", stCard});
		expTrace.push_back({"LW", 16'h0000});
		repeat (r.lockFails) expTrace.push_back({"LE", stCard});
		expTrace.push_back({"LC", stCard | stLocked});
		repeat (r.nrFails) expTrace.push_back({"NR", 16'h0000});
		expTrace.push_back({"RD", stReady});
		for (int i = 0; i < 6; i++) begin
			expTrace.push_back({tail[2*i], tail[2*i+1], 16'h0000});
		end
		// buffer keeps only the first entries
		while (expTrace.size() > `ACE_BUF_DEPTH) void'(expTrace.pop_back());
	endtask

	task automatic waitDone();
		int n;
		n = 0;
		while (!readDone && n < doneLimit) begin
			@(posedge sys_Ace_clk);
			n++;
		end
		checkTrue(readDone, "readDone did not arrive within the cycle limit");
	endtask

	task automatic checkWrites();
		int i;
		checkValue("writeCount", writeLog.size(), expWrites.size());
		for (i = 0; i < expWrites.size() && i < writeLog.size(); i++) begin
			checkValue($sformatf("write[%0d].addr", i), writeLog[i].addr, expWrites[i].addr);
			checkValue($sformatf("write[%0d].data", i), writeLog[i].data, expWrites[i].data);
		end
	endtask

	task automatic checkBuffers(input row_t r);
		int k;
		int n;
		n = expTrace.size();
		checkValue("wordCount", wordCount, `ACE_BUF_DEPTH);
		checkValue("traceCount", traceCount, n);
		for (k = 0; k < `ACE_BUF_DEPTH; k++) begin
			@(posedge sys_Ace_clk);
			wordIndex <= `ACE_IDX_W'(k);
			traceIndex <= `ACE_IDX_W'(k);
			@(posedge sys_Ace_clk);
			checkValue($sformatf("word[%0d]", k), word, aceWord_t'(r.lba[15:0] + k));
			if (k < n) checkValue($sformatf("trace[%0d]", k), trace, expTrace[k]);
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////
	initial begin
		int r;
		rst = 1'b1;
		readStart = 1'b0;
		sectorLba = '0;
		wordIndex = '0;
		traceIndex = '0;
		// lba, status fails, lock fails, not ready polls, error register
		rows[0] = '{28'h0000000, 2'd0, 2'd0, 2'd0, 16'h0000};
		rows[1] = '{28'h0123456, 2'd1, 2'd0, 2'd2, 16'h0001};
		rows[2] = '{28'hfffffff, 2'd2, 2'd2, 2'd2, 16'hbeef};
		rows[3] = '{28'h8badf00, 2'd0, 2'd1, 2'd0, 16'h0040};
		rows[4] = '{28'h000fff0, 2'd2, 2'd0, 2'd1, 16'h8000};
		rows[5] = '{28'h7654321, 2'd1, 2'd2, 2'd0, 16'h1234};
		repeat (2) @(posedge sys_Ace_clk);
		rst <= 1'b0;
		@(posedge sys_Ace_clk);
		// idle outputs before the first start
		checkValue("busy", busy, 32'h0);
		checkValue("readDone", readDone, 32'h0);
		checkValue("mpu.ceN", mpu.ceN, 32'h1);
		checkValue("mpu.oeN", mpu.oeN, 32'h1);
		checkValue("mpu.weN", mpu.weN, 32'h1);
		checkValue("mpu.doutEn", mpu.doutEn, 32'h0);
		for (r = 0; r < nRows; r++) begin
			@(posedge sys_Ace_clk);
			curRow <= rows[r];
			sectorLba <= rows[r].lba;
			readStart <= 1'b1;
			buildExpected(rows[r]);
			@(posedge sys_Ace_clk);
			readStart <= 1'b0;
			repeat (4) @(posedge sys_Ace_clk);
			// second start with another LBA while busy is ignored
			checkTrue(busy, "busy was not high after the start pulse");
			sectorLba <= ~rows[r].lba;
			readStart <= 1'b1;
			@(posedge sys_Ace_clk);
			readStart <= 1'b0;
			waitDone();
			checkWrites();
			checkBuffers(rows[r]);
		end
		$display("Summary: %0d value errors, %0d other errors, %0d assertion failures",
			valueErrs, otherErrs, i_dut.i_assertions.failCount);
		if (valueErrs + otherErrs + i_dut.i_assertions.failCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// watchdog with a budget per row
	initial begin
		repeat (nRows * doneLimit) @(posedge sys_Ace_clk);
		otherErrs++;
		$display("watchdog expired before all rows finished");
		$display("Summary: %0d value errors, %0d other errors, %0d assertion failures",
			valueErrs, otherErrs, i_dut.i_assertions.failCount);
		$display("Something failed");
		$finish;
	end

endmodule

/* tb.f */
+incdir+include
hdl/acePkg.sv
hdl/captureBuffer.sv
hdl/aceBusPort.sv
hdl/aceSequencer.sv
hdl/aceReader.sv
tb/aceReader_assertions.sv
tb/aceReader_tb.sv

/* Bender.yml */
package:
  name: ace_reader

export_include_dirs:
  - include

sources:
  - files:
      - hdl/acePkg.sv
      - hdl/captureBuffer.sv
      - hdl/aceBusPort.sv
      - hdl/aceSequencer.sv
      - hdl/aceReader.sv
  - target: test
    files:
      - tb/aceReader_assertions.sv
      - tb/aceReader_tb.sv
